// File: sim.f
+incdir+include
design/eg_pkg.sv
design/reg_host_if.sv
design/slot_timer.sv
design/rate_counter.sv
design/ksl_rom.sv
design/envelope_core.sv
design/level_fifo.sv
design/eg_top.sv
tests/tb_eg.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_eg -o tb_eg_sim &&
./obj_dir/tb_eg_sim > sim.log 2>&1 ||
echo "build or simulation stopped early"
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: include/eg_tb_table.svh
// row: writes wrs[0..nwr-1] (listed last first), key event, frames to run,
// expected atten and phase per slot, listed from slot 7 down to slot 0
rows[0] = '{nwr: 3'd0, key_en: 1'b0, key_slot: 3'd0, key_val: 1'b0, frames: 8'd1,
    wrs: {NO_WR, NO_WR, NO_WR},                        // idle after reset
    exp_att: {9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511},
    exp_ph: {REL, REL, REL, REL, REL, REL, REL, REL}};
rows[1] = '{nwr: 3'd2, key_en: 1'b1, key_slot: 3'd0, key_val: 1'b1, frames: 8'd3,
    wrs: {NO_WR, make_write(eg_pkg::REG_LEVELS, 3'd0, 8'hF0),   // sl 15 keeps decay
          make_write(eg_pkg::REG_RATES, 3'd0, 8'hF0)},         // ar 15, dr 0
    exp_att: {9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd0},
    exp_ph: {REL, REL, REL, REL, REL, REL, REL, DEC}};
rows[2] = '{nwr: 3'd3, key_en: 1'b1, key_slot: 3'd1, key_val: 1'b1, frames: 8'd12,
    wrs: {make_write(eg_pkg::REG_FLAGS, 3'd1, 8'h01),          // egt 1
          make_write(eg_pkg::REG_LEVELS, 3'd1, 8'h40),         // sl 4, rr 0
          make_write(eg_pkg::REG_RATES, 3'd1, 8'hFF)},         // steps of 8 land on 64
    exp_att: {9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd64, 9'd0},
    exp_ph: {REL, REL, REL, REL, REL, REL, SUS, DEC}};
rows[3] = '{nwr: 3'd2, key_en: 1'b1, key_slot: 3'd2, key_val: 1'b1, frames: 8'd12,
    wrs: {NO_WR, make_write(eg_pkg::REG_LEVELS, 3'd2, 8'h40),   // egt 0, falls to release
          make_write(eg_pkg::REG_RATES, 3'd2, 8'hFF)},
    exp_att: {9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd64, 9'd64, 9'd0},
    exp_ph: {REL, REL, REL, REL, REL, REL, SUS, DEC}};
rows[4] = '{nwr: 3'd1, key_en: 1'b1, key_slot: 3'd2, key_val: 1'b0, frames: 8'd60,
    wrs: {NO_WR, NO_WR, make_write(eg_pkg::REG_LEVELS, 3'd2, 8'h4F)},   // rr 15, 56 frames up
    exp_att: {9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd64, 9'd0},
    exp_ph: {REL, REL, REL, REL, REL, REL, SUS, DEC}};
rows[5] = '{nwr: 3'd1, key_en: 1'b0, key_slot: 3'd0, key_val: 1'b0, frames: 8'd1,
    wrs: {NO_WR, NO_WR, make_write(eg_pkg::REG_SCALE, 3'd0, 8'h0A)},   // tl 10 gives 40
    exp_att: {9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd64, 9'd40},
    exp_ph: {REL, REL, REL, REL, REL, REL, SUS, DEC}};
rows[6] = '{nwr: 3'd1, key_en: 1'b0, key_slot: 3'd0, key_val: 1'b0, frames: 8'd1,
    wrs: {NO_WR, NO_WR, make_write(eg_pkg::REG_FLAGS, 3'd0, 8'h02)},   // am on, dam 0 adds 13
    exp_att: {9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd64, 9'd53},
    exp_ph: {REL, REL, REL, REL, REL, REL, SUS, DEC}};
rows[7] = '{nwr: 3'd3, key_en: 1'b0, key_slot: 3'd0, key_val: 1'b0, frames: 8'd1,
    wrs: {make_write(eg_pkg::REG_FLAGS, 3'd0, 8'h00),          // am off again
          make_write(eg_pkg::REG_PITCH, 3'd0, 8'h77),          // fnum_hi 7, block 7
          make_write(eg_pkg::REG_SCALE, 3'd0, 8'hCA)},         // ksl 3 full, table value 56
    exp_att: {9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd64, 9'd96},
    exp_ph: {REL, REL, REL, REL, REL, REL, SUS, DEC}};
rows[8] = '{nwr: 3'd3, key_en: 1'b0, key_slot: 3'd0, key_val: 1'b0, frames: 8'd8,
    wrs: {make_write(eg_pkg::REG_FLAGS, 3'd2, 8'h02),
          make_write(eg_pkg::REG_PITCH, 3'd2, 8'h77),
          make_write(eg_pkg::REG_SCALE, 3'd2, 8'hFF)},         // 511 + 252 + 56 + 13 clamps
    exp_att: {9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd64, 9'd96},
    exp_ph: {REL, REL, REL, REL, REL, REL, SUS, DEC}};

// File: tests/tb_eg.sv
module tb_eg;

    localparam int NUM_SLOTS = eg_pkg::NUM_SLOTS;
    localparam int N_ROWS    = 9;
    localparam int HS_WORST  = 12;                     // cycles per result at the longest ack delay
    localparam int FRAME_GAP = 16;                     // drain, issue and pipe latency per frame
    localparam int MARGIN    = 400;                    // reset and host writes

    localparam logic [3:0] DEC = eg_pkg::DECAY;
    localparam logic [3:0] SUS = eg_pkg::SUSTAIN;
    localparam logic [3:0] REL = eg_pkg::RELEASE;
    localparam eg_pkg::host_wr_t NO_WR = '0;           // unused write entry

    typedef struct packed {
        logic [2:0]                nwr;                // writes used from wrs
        eg_pkg::host_wr_t [2:0]    wrs;                // [0] goes out first
        logic                      key_en;
        logic [eg_pkg::SLOT_W-1:0] key_slot;
        logic                      key_val;            // 1 = key on
        logic [7:0]                frames;             // frames after the writes
        logic [7:0][8:0]           exp_att;            // [s] is slot s
        logic [7:0][3:0]           exp_ph;
    } row_t;

    logic               clk = 1'b0;
    logic               rst_n;
    eg_pkg::host_wr_t   wr;
    logic               wr_req;
    logic               wr_ack;
    eg_pkg::eg_result_t res;
    logic               res_req;
    logic               res_ack;

    row_t       rows [N_ROWS];
    int         n_checks;
    int         n_errors;
    int         res_idx;                               // results taken so far
    int         wd_cycles;
    logic [8:0] got_att [NUM_SLOTS];                   // latest result per slot
    logic [3:0] got_ph  [NUM_SLOTS];
    logic       wr_req_q;
    logic       wr_ack_q;
    logic       res_req_q;
    logic       res_ack_q;

    eg_top #(.NUM_SLOTS(NUM_SLOTS)) u_dut (
        .clk(clk), .rst_n(rst_n), .wr(wr), .wr_req(wr_req), .wr_ack(wr_ack),
        .res(res), .res_req(res_req), .res_ack(res_ack)
    );

    always #50 clk = ~clk;

    function automatic eg_pkg::host_wr_t make_write(input eg_pkg::reg_addr_t addr,
                                                    input logic [2:0] slot,
                                                    input logic [7:0] data);
        return {addr, slot, data};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        n_checks++;
        if (exp_v !== act_v) begin
            n_errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
        end
    endtask

    task automatic load_rows();
        `include "eg_tb_table.svh"
    endtask

    // four-phase host write with the ack sampled on the falling edge
    task automatic host_write(input eg_pkg::host_wr_t w);
        @(posedge clk);
        wr     <= w;
        wr_req <= 1'b1;
        @(negedge clk);
        while (!wr_ack) @(negedge clk);
        @(posedge clk);
        wr_req <= 1'b0;
        @(negedge clk);
        while (wr_ack) @(negedge clk);                 // handshake closed
    endtask

    // consumer side with a random wait before each ack
    task automatic take_results(input int n);
        eg_pkg::eg_result_t r;
        int unsigned        delay;
        for (int k = 0; k < n; k++) begin
            delay = $urandom % 6;
            @(negedge clk);
            while (!res_req) @(negedge clk);
            r = res;                                   // held while req is high
            check_val("res.slot", res_idx % NUM_SLOTS, r.slot);   // no gaps or repeats
            res_idx++;
            got_att[r.slot] = r.atten;
            got_ph[r.slot]  = r.phase;
            repeat (delay) @(negedge clk);
            @(posedge clk);
            res_ack <= 1'b1;
            @(negedge clk);
            while (res_req) @(negedge clk);
            @(posedge clk);
            res_ack <= 1'b0;
        end
    endtask

    task automatic run_row(input row_t row, input int idx);
        take_results(6);                               // two results left keep the timer waiting
        for (int w = 0; w < int'(row.nwr); w++) begin
            host_write(row.wrs[w]);
        end
        if (row.key_en) begin
            host_write(make_write(eg_pkg::REG_KEY, row.key_slot, {7'd0, row.key_val}));
        end
        take_results(2);                               // close the frame already issued
        take_results(int'(row.frames) * NUM_SLOTS);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            check_val($sformatf("row %0d slot %0d atten", idx, s), row.exp_att[s], got_att[s]);
            check_val($sformatf("row %0d slot %0d phase", idx, s), row.exp_ph[s], got_ph[s]);
        end
    endtask

    // handshake order on both ports against the values the DUT sampled
    always @(negedge clk) begin
        if (rst_n) begin
            if (res_req && !res_req_q) check_val("res_ack at res_req rise", 0, res_ack_q);
            if (!res_req && res_req_q) check_val("res_ack at res_req fall", 1, res_ack_q);
            if (wr_ack && !wr_ack_q)   check_val("wr_req at wr_ack rise", 1, wr_req_q);
            if (!wr_ack && wr_ack_q)   check_val("wr_req at wr_ack fall", 0, wr_req_q);
        end
        wr_req_q  <= wr_req;
        wr_ack_q  <= wr_ack;
        res_req_q <= res_req;
        res_ack_q <= res_ack;
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout, the run did not end within %0d cycles", wd_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        wr       = '0;
        wr_req   = 1'b0;
        res_ack  = 1'b0;
        n_checks = 0;
        n_errors = 0;
        res_idx  = 0;
        void'($urandom(32'he98e));
        load_rows();
        wd_cycles = MARGIN;
        for (int i = 0; i < N_ROWS; i++) begin     // one extra frame per row around the writes
            wd_cycles += (int'(rows[i].frames) + 1) * (NUM_SLOTS * HS_WORST + FRAME_GAP);
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(rows[i], i);
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: design/eg_top.sv
module eg_top #(
    parameter int NUM_SLOTS = eg_pkg::NUM_SLOTS
) (
    input  logic               clk,
    input  logic               rst_n,
    input  eg_pkg::host_wr_t   wr,
    input  logic               wr_req,
    output logic               wr_ack,
    output eg_pkg::eg_result_t res,
    output logic               res_req,
    input  logic               res_ack
);

    logic [eg_pkg::SLOT_W-1:0] slot;
    logic                      slot_valid;
    eg_pkg::op_regs_t          regs;
    logic                      key_on;
    logic                      key_off;
    logic                      key_take;
    logic [3:0]                rate;
    logic [2:0]                block;
    logic                      ksr;
    logic [3:0]                step;
    logic [7:0]                ksl_add;
    logic                      push;
    eg_pkg::eg_result_t        core_res;
    logic                      fifo_empty;
    wire                       frame_start = slot_valid && (slot == '0);   // slot 0 issue

    reg_host_if #(.NUM_SLOTS(NUM_SLOTS)) u_reg_host_if (
        .clk(clk), .rst_n(rst_n), .wr(wr), .wr_req(wr_req), .wr_ack(wr_ack),
        .slot(slot), .regs(regs), .key_on(key_on), .key_off(key_off),
        .key_take(key_take)
    );

    slot_timer #(.NUM_SLOTS(NUM_SLOTS)) u_slot_timer (
        .clk(clk), .rst_n(rst_n), .fifo_empty(fifo_empty),
        .slot(slot), .slot_valid(slot_valid)
    );

    rate_counter u_rate_counter (
        .clk(clk), .rst_n(rst_n), .frame_start(frame_start),
        .rate(rate), .block(block), .ksr(ksr), .step(step)
    );

    ksl_rom u_ksl_rom (                                // looked up at issue time
        .fnum_hi(regs.fnum_hi), .block(regs.block), .ksl(regs.ksl), .ksl_add(ksl_add)
    );

    envelope_core #(.NUM_SLOTS(NUM_SLOTS)) u_envelope_core (
        .clk(clk), .rst_n(rst_n), .slot(slot), .slot_valid(slot_valid), .regs(regs),
        .key_on(key_on), .key_off(key_off), .key_take(key_take), .rate(rate),
        .block(block), .ksr(ksr), .step(step), .ksl_add(ksl_add),
        .push(push), .res(core_res)
    );

    level_fifo #(.NUM_SLOTS(NUM_SLOTS)) u_level_fifo (
        .clk(clk), .rst_n(rst_n), .push(push), .din(core_res), .fifo_empty(fifo_empty),
        .res(res), .res_req(res_req), .res_ack(res_ack)
    );

endmodule

// File: design/level_fifo.sv
module level_fifo #(
    parameter int NUM_SLOTS = eg_pkg::NUM_SLOTS
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  eg_pkg::eg_result_t din,
    output logic               fifo_empty,
    output eg_pkg::eg_result_t res,
    output logic               res_req,
    input  logic               res_ack
);

    localparam int AW = $clog2(NUM_SLOTS);
    localparam int CW = $clog2(NUM_SLOTS + 1);

    eg_pkg::eg_result_t mem [NUM_SLOTS];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    logic               wait_drop;                     // ack high, waiting for its fall
    logic               pop;

    assign pop        = !res_req && !wait_drop && (count != '0);   // head to port
    assign fifo_empty = (count == '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        if (pop) begin
            res <= mem[rd_ptr];                        // one cycle after head
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            res_req   <= 1'b0;
            wait_drop <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(NUM_SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(NUM_SLOTS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);

            if (pop) begin
                res_req <= 1'b1;
            end else if (res_req && res_ack) begin
                res_req   <= 1'b0;
                wait_drop <= 1'b1;
            end else if (wait_drop && !res_ack) begin
                wait_drop <= 1'b0;                     // handover done
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> int'(count) < NUM_SLOTS);

endmodule

// File: design/envelope_core.sv
module envelope_core #(
    parameter int NUM_SLOTS = eg_pkg::NUM_SLOTS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [eg_pkg::SLOT_W-1:0] slot,
    input  logic                      slot_valid,
    input  eg_pkg::op_regs_t          regs,
    input  logic                      key_on,
    input  logic                      key_off,
    output logic                      key_take,
    output logic [3:0]                rate,
    output logic [2:0]                block,
    output logic                      ksr,
    input  logic [3:0]                step,
    input  logic [7:0]                ksl_add,
    output logic                      push,
    output eg_pkg::eg_result_t        res
);

    localparam int ENV_W = eg_pkg::ENV_W;

    eg_pkg::eg_phase_e phase_mem [NUM_SLOTS];
    logic [ENV_W-1:0]  env_mem   [NUM_SLOTS];

    logic                      s1_valid;
    logic [eg_pkg::SLOT_W-1:0] s1_slot;
    eg_pkg::eg_phase_e         s1_phase;
    logic [ENV_W-1:0]          s1_env;
    eg_pkg::op_regs_t          s1_regs;
    logic [7:0]                s1_ksl;
    eg_pkg::eg_phase_e         next_phase;

    logic                      s2_valid;
    logic [eg_pkg::SLOT_W-1:0] s2_slot;
    eg_pkg::eg_phase_e         s2_phase;
    logic [ENV_W-1:0]          s2_env;
    eg_pkg::op_regs_t          s2_regs;
    logic [7:0]                s2_ksl;
    logic [3:0]                s2_step;
    logic [12:0]               att_prod;               // env * step
    logic [ENV_W:0]            att_dec;
    logic [ENV_W:0]            rel_sum;
    logic [ENV_W-1:0]          env_next;

    logic                      s3_valid;
    logic [eg_pkg::SLOT_W-1:0] s3_slot;
    eg_pkg::eg_phase_e         s3_phase;
    logic [ENV_W-1:0]          s3_env;
    eg_pkg::op_regs_t          s3_regs;
    logic [7:0]                s3_ksl;
    logic [3:0]                am_add;
    logic [10:0]               level_sum;              // wide enough for every offset

    assign key_take = slot_valid && (key_on || key_off);   // event leaves the reg file

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            push     <= 1'b0;
        end else begin
            s1_valid <= slot_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            push     <= s3_valid;                      // 4 cycles after issue
        end
    end

    // stage 1: memory read, key event applied
    always_ff @(posedge clk) begin
        s1_slot  <= slot;
        s1_env   <= env_mem[slot];
        s1_regs  <= regs;
        s1_ksl   <= ksl_add;
        if (key_on) begin
            s1_phase <= eg_pkg::ATTACK;                // key on wins
        end else if (key_off) begin
            s1_phase <= eg_pkg::RELEASE;
        end else begin
            s1_phase <= phase_mem[slot];
        end
    end

    // stage 2: phase transition and rate request
    always_comb begin
        next_phase = s1_phase;
        case (s1_phase)
            eg_pkg::ATTACK:  if (s1_env == '0) next_phase = eg_pkg::DECAY;
            eg_pkg::DECAY:   if ((s1_env >> 4) >= s1_regs.sl) next_phase = eg_pkg::SUSTAIN;
            eg_pkg::SUSTAIN: if (!s1_regs.egt) next_phase = eg_pkg::RELEASE;
            default: ;
        endcase
        case (next_phase)
            eg_pkg::ATTACK:  rate = s1_regs.ar;
            eg_pkg::DECAY:   rate = s1_regs.dr;
            eg_pkg::RELEASE: rate = s1_regs.rr;
            default:         rate = 4'd0;              // sustain holds
        endcase
    end

    assign block = s1_regs.block;
    assign ksr   = s1_regs.ksr;

    always_ff @(posedge clk) begin
        s2_slot  <= s1_slot;
        s2_phase <= next_phase;
        s2_env   <= s1_env;
        s2_regs  <= s1_regs;
        s2_ksl   <= s1_ksl;
        s2_step  <= step;
    end

    // stage 3: envelope step
    always_comb begin
        att_prod = s2_env * s2_step;
        att_dec  = att_prod[12:3] + 10'd1;
        rel_sum  = {1'b0, s2_env} + {6'b0, s2_step};
        env_next = s2_env;
        case (s2_phase)
            eg_pkg::ATTACK: begin
                if (s2_step != '0) begin
                    env_next = (att_dec >= {1'b0, s2_env}) ? '0 : s2_env - att_dec[ENV_W-1:0];
                end
            end
            eg_pkg::DECAY, eg_pkg::RELEASE: begin
                env_next = (rel_sum > {1'b0, eg_pkg::SILENCE}) ? eg_pkg::SILENCE
                                                               : rel_sum[ENV_W-1:0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                phase_mem[i] <= eg_pkg::RELEASE;       // silent after reset
                env_mem[i]   <= eg_pkg::SILENCE;
            end
        end else if (s2_valid) begin
            phase_mem[s2_slot] <= s2_phase;            // write back
            env_mem[s2_slot]   <= env_next;
        end
    end

    always_ff @(posedge clk) begin
        s3_slot  <= s2_slot;
        s3_phase <= s2_phase;
        s3_env   <= env_next;
        s3_regs  <= s2_regs;
        s3_ksl   <= s2_ksl;
    end

    // stage 4: level sum and clamp
    always_comb begin
        am_add = 4'd0;
        if (s3_regs.am) begin
            am_add = s3_regs.dam ? 4'd4 : 4'd13;       // fixed tremolo depth
        end
        level_sum = {2'b0, s3_env} + {3'b0, s3_regs.tl, 2'b00}
                  + {3'b0, s3_ksl} + {7'b0, am_add};
    end

    always_ff @(posedge clk) begin
        if (s3_valid) begin
            res.slot  <= s3_slot;
            res.phase <= s3_phase;
            res.atten <= (level_sum > 11'd511) ? eg_pkg::SILENCE : level_sum[ENV_W-1:0];
        end
    end

    a_phase_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        slot_valid |-> $onehot(phase_mem[slot]));

endmodule

// File: design/ksl_rom.sv
module ksl_rom (
    input  logic [2:0] fnum_hi,
    input  logic [2:0] block,
    input  logic [1:0] ksl,
    output logic [7:0] ksl_add
);

    logic [5:0] tbl;                                   // attenuation per fnum octave step
    logic [7:0] raw;
    logic [7:0] base;

    always_comb begin
        case (fnum_hi)
            3'd0:    tbl = 6'd0;
            3'd1:    tbl = 6'd32;
            3'd2:    tbl = 6'd40;
            3'd3:    tbl = 6'd45;
            3'd4:    tbl = 6'd48;
            3'd5:    tbl = 6'd51;
            3'd6:    tbl = 6'd53;
            default: tbl = 6'd56;
        endcase

        raw  = {2'b00, tbl} + {2'b00, block, 3'b000};  // table + 8 * block
        base = (raw > 8'd56) ? raw - 8'd56 : 8'd0;     // floored at 0

        case (ksl)
            2'd0:    ksl_add = 8'd0;                   // off
            2'd1:    ksl_add = base >> 1;              // half
            2'd2:    ksl_add = base >> 2;              // quarter
            default: ksl_add = base;                   // full
        endcase
    end

endmodule

// File: design/rate_counter.sv
module rate_counter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       frame_start,
    input  logic [3:0] rate,
    input  logic [2:0] block,
    input  logic       ksr,
    output logic [3:0] step
);

    logic [13:0] frame_cnt;                            // global sample counter
    logic [6:0]  eff_raw;
    logic [5:0]  eff;                                  // effective rate 0..63
    logic [3:0]  shift;                                // log2 of the step period
    logic [13:0] mask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (frame_start) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    always_comb begin
        eff_raw = {1'b0, rate, 2'b00} + {4'b0, (ksr ? block : block >> 1)};
        eff     = (eff_raw > 7'd63) ? 6'd63 : eff_raw[5:0];   // cap
        shift   = 4'd15 - eff[5:2];                    // slower rates get a longer period
        mask    = (14'd1 << shift) - 14'd1;

        if (rate == '0) begin
            step = 4'd0;                               // rate 0 holds
        end else if (eff >= 6'd60) begin
            step = 4'd8;                               // fastest rates step every frame
        end else if ((frame_cnt & mask) == '0) begin
            step = 4'd1;
        end else begin
            step = 4'd0;
        end
    end

endmodule

// File: design/slot_timer.sv
module slot_timer #(
    parameter int NUM_SLOTS = eg_pkg::NUM_SLOTS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fifo_empty,
    output logic [eg_pkg::SLOT_W-1:0] slot,
    output logic                      slot_valid
);

    localparam int PIPE_LAT = 4;                       // issue to push in the core

    logic [eg_pkg::SLOT_W-1:0] cnt;
    logic                      running;
    logic [2:0]                drain;                  // cycles until last push lands

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt     <= '0;
            running <= 1'b0;
            drain   <= '0;
        end else if (running) begin
            if (cnt == eg_pkg::SLOT_W'(NUM_SLOTS - 1)) begin
                running <= 1'b0;                       // frame issued
                cnt     <= '0;
                drain   <= 3'(PIPE_LAT);
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (drain != '0) begin
            drain <= drain - 1'b1;                     // let the pipe empty out
        end else if (fifo_empty) begin
            running <= 1'b1;                           // room for a whole frame
        end
    end

    assign slot       = cnt;
    assign slot_valid = running;

    a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
        slot_valid |-> int'(slot) < NUM_SLOTS);

endmodule

// File: design/reg_host_if.sv
module reg_host_if #(
    parameter int NUM_SLOTS = eg_pkg::NUM_SLOTS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  eg_pkg::host_wr_t          wr,
    input  logic                      wr_req,
    output logic                      wr_ack,
    input  logic [eg_pkg::SLOT_W-1:0] slot,
    output eg_pkg::op_regs_t          regs,
    output logic                      key_on,
    output logic                      key_off,
    input  logic                      key_take
);

    eg_pkg::op_regs_t     regs_mem [NUM_SLOTS];        // per-slot register file
    logic [NUM_SLOTS-1:0] kon_q;                       // pending key on
    logic [NUM_SLOTS-1:0] koff_q;                      // pending key off
    logic                 wr_take;

    assign wr_take = wr_req && !wr_ack;                // new request, not yet acked

    // four-phase ack: rise on req, fall once req is gone
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ack <= 1'b0;
        end else if (wr_take) begin
            wr_ack <= 1'b1;
        end else if (!wr_req && wr_ack) begin
            wr_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                regs_mem[i] <= '0;
            end
            kon_q  <= '0;
            koff_q <= '0;
        end else begin
            if (key_take) begin                        // core consumed the event
                kon_q[slot]  <= 1'b0;
                koff_q[slot] <= 1'b0;
            end
            if (wr_take) begin                         // a new write beats the clear
                case (wr.addr)
                    eg_pkg::REG_RATES: begin
                        regs_mem[wr.slot].ar <= wr.data.nib.hi;
                        regs_mem[wr.slot].dr <= wr.data.nib.lo;
                    end
                    eg_pkg::REG_LEVELS: begin
                        regs_mem[wr.slot].sl <= wr.data.nib.hi;
                        regs_mem[wr.slot].rr <= wr.data.nib.lo;
                    end
                    eg_pkg::REG_SCALE: begin           // other view of the byte
                        regs_mem[wr.slot].ksl <= wr.data.kt.ksl;
                        regs_mem[wr.slot].tl  <= wr.data.kt.tl;
                    end
                    eg_pkg::REG_PITCH: begin
                        regs_mem[wr.slot].fnum_hi <= wr.data.nib.hi[2:0];
                        regs_mem[wr.slot].block   <= wr.data.nib.lo[2:0];
                        regs_mem[wr.slot].ksr     <= wr.data.nib.lo[3];
                    end
                    eg_pkg::REG_FLAGS: begin
                        regs_mem[wr.slot].egt <= wr.data.nib.lo[0];
                        regs_mem[wr.slot].am  <= wr.data.nib.lo[1];
                        regs_mem[wr.slot].dam <= wr.data.nib.lo[2];
                    end
                    eg_pkg::REG_KEY: begin
                        if (wr.data.nib.lo[0]) begin
                            kon_q[wr.slot] <= 1'b1;
                        end else begin
                            koff_q[wr.slot] <= 1'b1;
                        end
                    end
                    default: ;                         // unused group codes
                endcase
            end
        end
    end

    assign regs    = regs_mem[slot];                   // current slot view
    assign key_on  = kon_q[slot];
    assign key_off = koff_q[slot];

    a_wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req && !wr_ack |=> !wr_req || $stable(wr));

endmodule

// File: design/eg_pkg.sv
package eg_pkg;

    localparam int NUM_SLOTS = 8;                      // operator slots per frame
    localparam int SLOT_W    = 3;                      // slot index width
    localparam int ENV_W     = 9;                      // envelope / attenuation width
    localparam logic [ENV_W-1:0] SILENCE = 9'd511;     // max attenuation

    // one-hot so a stuck or corrupted phase is easy to spot
    typedef enum logic [3:0] {
        ATTACK  = 4'b0001,
        DECAY   = 4'b0010,
        SUSTAIN = 4'b0100,
        RELEASE = 4'b1000
    } eg_phase_e;

    typedef enum logic [2:0] {
        REG_RATES  = 3'd0,                             // ar / dr
        REG_LEVELS = 3'd1,                             // sl / rr
        REG_SCALE  = 3'd2,                             // ksl / tl
        REG_PITCH  = 3'd3,                             // fnum high / block / ksr
        REG_FLAGS  = 3'd4,                             // egt / am / dam
        REG_KEY    = 3'd5                              // key on / off event
    } reg_addr_t;

    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] lo;
    } nib_pair_t;

    typedef struct packed {
        logic [1:0] ksl;
        logic [5:0] tl;
    } ksl_tl_t;

    // data byte, split by the address group
    typedef union packed {
        nib_pair_t nib;
        ksl_tl_t   kt;
    } reg_byte_u;

    typedef struct packed {
        reg_addr_t         addr;
        logic [SLOT_W-1:0] slot;
        reg_byte_u         data;
    } host_wr_t;                                       // 14 bits

    typedef struct packed {
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;
        logic [3:0] rr;
        logic [1:0] ksl;
        logic [5:0] tl;
        logic [2:0] fnum_hi;
        logic [2:0] block;
        logic       ksr;
        logic       egt;                               // 1 = hold in sustain
        logic       am;
        logic       dam;
    } op_regs_t;

    typedef struct packed {
        logic [SLOT_W-1:0] slot;
        eg_phase_e         phase;
        logic [ENV_W-1:0]  atten;
    } eg_result_t;                                     // 16 bits

endpackage
